/* video_fmt_pkg.sv */
`default_nettype none

package video_fmt_pkg;

  // test raster, active area inside a larger total
  localparam int h_active = 32;
  localparam int h_total = 40;
  localparam int v_active = 20;
  localparam int v_total = 24;

  localparam int h_count_width = 11;
  localparam int v_count_width = 10;

  // line memory address, enough for h_total columns
  localparam int h_addr_width = $clog2(h_total);

  localparam int pixel_width = 24;
  localparam int chan_width = 8;
  localparam int quant_width = 6;
  localparam int quant_pixel_width = 3 * quant_width;

  localparam int kernel_taps = 9;

  // dither 1, line buffer 1, vertical 3, horizontal 3
  localparam int pipe_latency = 8;

endpackage

`default_nettype wire

/* blur_coeff_pkg.sv */
`default_nettype none

package blur_coeff_pkg;

  // code matches cutoff[9:8]
  typedef enum logic [1:0] {
    strength_none   = 2'd0,
    strength_light  = 2'd1,
    strength_medium = 2'd2,
    strength_heavy  = 2'd3
  } blur_strength_e;

  localparam int coeff_width = 9;
  localparam int coeff_count = 5;

  // c0 + 2*(c1+c2+c3+c4) = 256 in every row
  localparam logic [coeff_width-1:0] coeff_table [4][coeff_count] = '{
    '{9'd256, 9'd0, 9'd0, 9'd0, 9'd0},
    '{9'd128, 9'd64, 9'd0, 9'd0, 9'd0},
    '{9'd72, 9'd56, 9'd27, 9'd8, 9'd1},
    '{9'd40, 9'd36, 9'd30, 9'd22, 9'd20}
  };

  // tap i uses coefficient |i - centre|
  function automatic int tap_coeff(input int tap);
    int centre;
    centre = coeff_count - 1;
    return (tap < centre) ? centre - tap : tap - centre;
  endfunction

endpackage

`default_nettype wire

/* dither_quantize.sv */
`timescale 1ns/100ps
`default_nettype none

module dither_quantize (
  input  wire                                              clk,
  input  wire                                              rst,
  input  wire  [video_fmt_pkg::h_count_width-1:0]          h_count_in,
  input  wire  [video_fmt_pkg::v_count_width-1:0]          v_count_in,
  input  wire                                              active_draw_in,
  input  wire  [video_fmt_pkg::pixel_width-1:0]            pixel_in,
  output logic [video_fmt_pkg::h_count_width-1:0]          h_count_out,
  output logic [video_fmt_pkg::v_count_width-1:0]          v_count_out,
  output logic                                             active_draw_out,
  output logic [video_fmt_pkg::quant_pixel_width-1:0]      quant_pixel_out
);

  logic [1:0] dither;
  logic [video_fmt_pkg::quant_pixel_width-1:0] quant_next;

  // 2x2 ordered pattern
  always_comb begin
    case ({v_count_in[0], h_count_in[0]})
      2'b00: dither = 2'd0;
      2'b01: dither = 2'd2;
      2'b10: dither = 2'd3;
      default: dither = 2'd1;
    endcase
  end

  for (genvar c = 0; c < 3; c++) begin : g_chan
    logic [video_fmt_pkg::chan_width:0] dithered;

    assign dithered = {1'b0, pixel_in[c*video_fmt_pkg::chan_width +: video_fmt_pkg::chan_width]}
                      + {{(video_fmt_pkg::chan_width - 1){1'b0}}, dither};
    // carry out means saturate to full scale
    assign quant_next[c*video_fmt_pkg::quant_width +: video_fmt_pkg::quant_width] =
        dithered[video_fmt_pkg::chan_width] ? '1 :
        dithered[video_fmt_pkg::chan_width-1 -: video_fmt_pkg::quant_width];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      h_count_out <= '0;
      v_count_out <= '0;
      active_draw_out <= 1'b0;
      quant_pixel_out <= '0;
    end else begin
      h_count_out <= h_count_in;
      v_count_out <= v_count_in;
      active_draw_out <= active_draw_in;
      quant_pixel_out <= quant_next;
    end
  end

endmodule

`default_nettype wire

/* line_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module line_buffer (
  input  wire                                              clk,
  input  wire                                              rst,
  input  wire  [video_fmt_pkg::h_count_width-1:0]          h_count_in,
  input  wire  [video_fmt_pkg::v_count_width-1:0]          v_count_in,
  input  wire                                              active_draw_in,
  input  wire  [video_fmt_pkg::quant_pixel_width-1:0]      quant_pixel_in,
  output logic [video_fmt_pkg::h_count_width-1:0]          h_count_out,
  output logic [video_fmt_pkg::v_count_width-1:0]          v_count_out,
  output logic                                             active_draw_out,
  output logic [video_fmt_pkg::kernel_taps-1:0][video_fmt_pkg::quant_pixel_width-1:0] column_taps
);

  logic [video_fmt_pkg::quant_pixel_width-1:0]
      line_mem [video_fmt_pkg::kernel_taps-1][video_fmt_pkg::h_total];
  logic [video_fmt_pkg::kernel_taps-2:0] line_valid;

  logic [2:0] wr_sel;
  logic [video_fmt_pkg::h_addr_width-1:0] addr;
  logic [video_fmt_pkg::kernel_taps-1:0][video_fmt_pkg::quant_pixel_width-1:0] taps_next;

  // eight lines, so the low three row bits pick the line
  assign wr_sel = v_count_in[2:0];
  assign addr = h_count_in[video_fmt_pkg::h_addr_width-1:0];

  // old contents of the line being written are row v-8
  always_comb begin
    logic [2:0] sel;
    for (int k = 0; k < video_fmt_pkg::kernel_taps - 1; k++) begin
      sel = wr_sel + 3'(k);
      taps_next[k] = line_valid[sel] ? line_mem[sel][addr] : '0;
    end
    taps_next[video_fmt_pkg::kernel_taps-1] = quant_pixel_in;
  end

  always_ff @(posedge clk) begin
    line_mem[wr_sel][addr] <= quant_pixel_in;
  end

  // a line only feeds taps once it holds a complete row
  always_ff @(posedge clk) begin
    if (rst) begin
      line_valid <= '0;
    end else if (h_count_in == video_fmt_pkg::h_count_width'(video_fmt_pkg::h_total - 1)) begin
      line_valid[wr_sel] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      h_count_out <= '0;
      v_count_out <= '0;
      active_draw_out <= 1'b0;
      column_taps <= '0;
    end else begin
      h_count_out <= h_count_in;
      v_count_out <= v_count_in;
      active_draw_out <= active_draw_in;
      column_taps <= taps_next;
    end
  end

endmodule

`default_nettype wire

/* coeff_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module coeff_bank (
  input  wire                                              clk,
  input  wire                                              rst,
  input  wire  [9:0]                                       cutoff,
  input  wire  [video_fmt_pkg::h_count_width-1:0]          h_count_out,
  input  wire  [video_fmt_pkg::v_count_width-1:0]          v_count_out,
  output logic [blur_coeff_pkg::coeff_count-1:0][blur_coeff_pkg::coeff_width-1:0] coeffs
);

  blur_coeff_pkg::blur_strength_e strength;
  logic frame_boundary;

  // first blanking pixel after the last active row leaves the pipeline
  assign frame_boundary =
      (h_count_out == video_fmt_pkg::h_count_width'(video_fmt_pkg::h_active)) &&
      (v_count_out == video_fmt_pkg::v_count_width'(video_fmt_pkg::v_active));

  always_ff @(posedge clk) begin
    if (rst) begin
      strength <= blur_coeff_pkg::strength_none;
    end else if (frame_boundary) begin
      strength <= blur_coeff_pkg::blur_strength_e'(cutoff[9:8]);
    end
  end

  always_comb begin
    for (int i = 0; i < blur_coeff_pkg::coeff_count; i++) begin
      coeffs[i] = blur_coeff_pkg::coeff_table[strength][i];
    end
  end

endmodule

`default_nettype wire

/* vertical_blur.sv */
`timescale 1ns/100ps
`default_nettype none

module vertical_blur (
  input  wire                                              clk,
  input  wire                                              rst,
  input  wire  [video_fmt_pkg::h_count_width-1:0]          h_count_in,
  input  wire  [video_fmt_pkg::v_count_width-1:0]          v_count_in,
  input  wire                                              active_draw_in,
  input  wire  [video_fmt_pkg::kernel_taps-1:0][video_fmt_pkg::quant_pixel_width-1:0] column_taps,
  input  wire  [blur_coeff_pkg::coeff_count-1:0][blur_coeff_pkg::coeff_width-1:0] coeffs,
  output logic [video_fmt_pkg::h_count_width-1:0]          h_count_out,
  output logic [video_fmt_pkg::v_count_width-1:0]          v_count_out,
  output logic                                             active_draw_out,
  output logic [video_fmt_pkg::chan_width-1:0]             vert_r,
  output logic [video_fmt_pkg::chan_width-1:0]             vert_g,
  output logic [video_fmt_pkg::chan_width-1:0]             vert_b
);

  // 6-bit tap times 9-bit coefficient
  logic [2:0][video_fmt_pkg::kernel_taps-1:0][14:0] prod;
  logic [2:0][2:0][14:0] part;
  logic [2:0][14:0] total;

  logic [2:0][video_fmt_pkg::h_count_width-1:0] h_pipe;
  logic [2:0][video_fmt_pkg::v_count_width-1:0] v_pipe;
  logic [2:0] active_pipe;

  always_ff @(posedge clk) begin
    if (rst) begin
      prod <= '0;
      part <= '0;
      total <= '0;
    end else begin
      for (int c = 0; c < 3; c++) begin
        for (int i = 0; i < video_fmt_pkg::kernel_taps; i++) begin
          prod[c][i] <= column_taps[i][c*video_fmt_pkg::quant_width +: video_fmt_pkg::quant_width]
                        * coeffs[blur_coeff_pkg::tap_coeff(i)];
        end
        for (int p = 0; p < 3; p++) begin
          part[c][p] <= prod[c][3*p] + prod[c][3*p+1] + prod[c][3*p+2];
        end
        // columns in horizontal blanking give zero
        if (h_pipe[1] >= video_fmt_pkg::h_count_width'(video_fmt_pkg::h_active)) begin
          total[c] <= '0;
        end else begin
          total[c] <= part[c][0] + part[c][1] + part[c][2];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      h_pipe <= '0;
      v_pipe <= '0;
      active_pipe <= '0;
    end else begin
      h_pipe <= {h_pipe[1:0], h_count_in};
      v_pipe <= {v_pipe[1:0], v_count_in};
      active_pipe <= {active_pipe[1:0], active_draw_in};
    end
  end

  assign h_count_out = h_pipe[2];
  assign v_count_out = v_pipe[2];
  assign active_draw_out = active_pipe[2];

  // sum / 64, red in the top channel
  assign vert_r = total[2][13:6];
  assign vert_g = total[1][13:6];
  assign vert_b = total[0][13:6];

endmodule

`default_nettype wire

/* horizontal_blur.sv */
`timescale 1ns/100ps
`default_nettype none

module horizontal_blur (
  input  wire                                              clk,
  input  wire                                              rst,
  input  wire  [video_fmt_pkg::h_count_width-1:0]          h_count_in,
  input  wire  [video_fmt_pkg::v_count_width-1:0]          v_count_in,
  input  wire                                              active_draw_in,
  input  wire  [video_fmt_pkg::chan_width-1:0]             vert_r,
  input  wire  [video_fmt_pkg::chan_width-1:0]             vert_g,
  input  wire  [video_fmt_pkg::chan_width-1:0]             vert_b,
  input  wire  [blur_coeff_pkg::coeff_count-1:0][blur_coeff_pkg::coeff_width-1:0] coeffs,
  output logic [video_fmt_pkg::h_count_width-1:0]          h_count_out,
  output logic [video_fmt_pkg::v_count_width-1:0]          v_count_out,
  output logic                                             active_draw_out,
  output logic [video_fmt_pkg::pixel_width-1:0]            pixel_out
);

  logic [2:0][video_fmt_pkg::chan_width-1:0] vert_in;
  logic [2:0][video_fmt_pkg::kernel_taps-1:0][video_fmt_pkg::chan_width-1:0] hbuf;
  // 8-bit sample times 9-bit coefficient
  logic [2:0][video_fmt_pkg::kernel_taps-1:0][16:0] prod;
  logic [2:0][2:0][16:0] part;
  logic [2:0][16:0] sum;

  logic [2:0][video_fmt_pkg::h_count_width-1:0] h_pipe;
  logic [2:0][video_fmt_pkg::v_count_width-1:0] v_pipe;
  logic [2:0] active_pipe;

  assign vert_in = {vert_r, vert_g, vert_b};

  always_comb begin
    for (int c = 0; c < 3; c++) begin
      for (int i = 0; i < video_fmt_pkg::kernel_taps; i++) begin
        prod[c][i] = hbuf[c][i] * coeffs[blur_coeff_pkg::tap_coeff(i)];
      end
      sum[c] = part[c][0] + part[c][1] + part[c][2];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hbuf <= '0;
      part <= '0;
      pixel_out <= '0;
    end else begin
      for (int c = 0; c < 3; c++) begin
        // newest column enters at index 0
        hbuf[c] <= {hbuf[c][video_fmt_pkg::kernel_taps-2:0], vert_in[c]};
        for (int p = 0; p < 3; p++) begin
          part[c][p] <= prod[c][3*p] + prod[c][3*p+1] + prod[c][3*p+2];
        end
      end
      pixel_out <= {sum[2][15:8], sum[1][15:8], sum[0][15:8]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      h_pipe <= '0;
      v_pipe <= '0;
      active_pipe <= '0;
    end else begin
      h_pipe <= {h_pipe[1:0], h_count_in};
      v_pipe <= {v_pipe[1:0], v_count_in};
      active_pipe <= {active_pipe[1:0], active_draw_in};
    end
  end

  assign h_count_out = h_pipe[2];
  assign v_count_out = v_pipe[2];
  assign active_draw_out = active_pipe[2];

endmodule

`default_nettype wire

/* gaussian_blur_top.sv */
`timescale 1ns/100ps
`default_nettype none

module gaussian_blur_top (
  input  wire                                              clk,
  input  wire                                              rst,
  input  wire  [video_fmt_pkg::h_count_width-1:0]          h_count_in,
  input  wire  [video_fmt_pkg::v_count_width-1:0]          v_count_in,
  input  wire                                              active_draw_in,
  input  wire  [video_fmt_pkg::pixel_width-1:0]            pixel_in,
  input  wire  [9:0]                                       cutoff,
  output logic [video_fmt_pkg::h_count_width-1:0]          h_count_out,
  output logic [video_fmt_pkg::v_count_width-1:0]          v_count_out,
  output logic                                             active_draw_out,
  output logic [video_fmt_pkg::pixel_width-1:0]            pixel_out
);

  logic [video_fmt_pkg::h_count_width-1:0] dq_h_count;
  logic [video_fmt_pkg::v_count_width-1:0] dq_v_count;
  logic dq_active_draw;
  logic [video_fmt_pkg::quant_pixel_width-1:0] dq_pixel;

  logic [video_fmt_pkg::h_count_width-1:0] lb_h_count;
  logic [video_fmt_pkg::v_count_width-1:0] lb_v_count;
  logic lb_active_draw;
  logic [video_fmt_pkg::kernel_taps-1:0][video_fmt_pkg::quant_pixel_width-1:0] column_taps;

  logic [video_fmt_pkg::h_count_width-1:0] vb_h_count;
  logic [video_fmt_pkg::v_count_width-1:0] vb_v_count;
  logic vb_active_draw;
  logic [video_fmt_pkg::chan_width-1:0] vert_r;
  logic [video_fmt_pkg::chan_width-1:0] vert_g;
  logic [video_fmt_pkg::chan_width-1:0] vert_b;

  logic [blur_coeff_pkg::coeff_count-1:0][blur_coeff_pkg::coeff_width-1:0] coeffs;

  dither_quantize dither_quantize_inst (
    .clk(clk),
    .rst(rst),
    .h_count_in(h_count_in),
    .v_count_in(v_count_in),
    .active_draw_in(active_draw_in),
    .pixel_in(pixel_in),
    .h_count_out(dq_h_count),
    .v_count_out(dq_v_count),
    .active_draw_out(dq_active_draw),
    .quant_pixel_out(dq_pixel)
  );

  line_buffer line_buffer_inst (
    .clk(clk),
    .rst(rst),
    .h_count_in(dq_h_count),
    .v_count_in(dq_v_count),
    .active_draw_in(dq_active_draw),
    .quant_pixel_in(dq_pixel),
    .h_count_out(lb_h_count),
    .v_count_out(lb_v_count),
    .active_draw_out(lb_active_draw),
    .column_taps(column_taps)
  );

  vertical_blur vertical_blur_inst (
    .clk(clk),
    .rst(rst),
    .h_count_in(lb_h_count),
    .v_count_in(lb_v_count),
    .active_draw_in(lb_active_draw),
    .column_taps(column_taps),
    .coeffs(coeffs),
    .h_count_out(vb_h_count),
    .v_count_out(vb_v_count),
    .active_draw_out(vb_active_draw),
    .vert_r(vert_r),
    .vert_g(vert_g),
    .vert_b(vert_b)
  );

  horizontal_blur horizontal_blur_inst (
    .clk(clk),
    .rst(rst),
    .h_count_in(vb_h_count),
    .v_count_in(vb_v_count),
    .active_draw_in(vb_active_draw),
    .vert_r(vert_r),
    .vert_g(vert_g),
    .vert_b(vert_b),
    .coeffs(coeffs),
    .h_count_out(h_count_out),
    .v_count_out(v_count_out),
    .active_draw_out(active_draw_out),
    .pixel_out(pixel_out)
  );

  // strength follows the final output counts
  coeff_bank coeff_bank_inst (
    .clk(clk),
    .rst(rst),
    .cutoff(cutoff),
    .h_count_out(h_count_out),
    .v_count_out(v_count_out),
    .coeffs(coeffs)
  );

endmodule

`default_nettype wire

/* tb_gaussian_blur.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_gaussian_blur;

  localparam int clk_period = 8;
  localparam int frame_cycles = video_fmt_pkg::h_total * video_fmt_pkg::v_total;
  // seven frames in the sequence below, two more as margin
  localparam int test_frames = 7;
  localparam int timeout_ns = (test_frames + 2) * frame_cycles * clk_period;
  localparam int centre_tap = video_fmt_pkg::kernel_taps / 2;
  localparam int span = video_fmt_pkg::kernel_taps - 1;
  localparam int impulse_h = 16;
  localparam int impulse_v = 12;
  localparam logic [31:0] lcg_seed = 32'h3d26_8ec8;

  typedef logic [video_fmt_pkg::h_count_width-1:0] h_count_t;
  typedef logic [video_fmt_pkg::v_count_width-1:0] v_count_t;
  typedef logic [video_fmt_pkg::pixel_width-1:0] pixel_t;
  typedef struct packed {
    h_count_t h;
    v_count_t v;
    logic active;
  } count_sample_t;

  logic clk;
  logic rst;
  h_count_t h_count_in;
  v_count_t v_count_in;
  logic active_draw_in;
  pixel_t pixel_in;
  logic [9:0] cutoff;
  h_count_t h_count_out;
  v_count_t v_count_out;
  logic active_draw_out;
  pixel_t pixel_out;

  pixel_t frame [video_fmt_pkg::v_active][video_fmt_pkg::h_active];
  pixel_t captured [video_fmt_pkg::v_total][video_fmt_pkg::h_total];
  count_sample_t input_history [$];
  logic latency_check_en;
  logic [1:0] pending_strength;
  logic [1:0] frame_strength;
  logic [31:0] lcg_state;
  int errors;
  int checks;

  gaussian_blur_top gaussian_blur_top_inst (
    .clk(clk),
    .rst(rst),
    .h_count_in(h_count_in),
    .v_count_in(v_count_in),
    .active_draw_in(active_draw_in),
    .pixel_in(pixel_in),
    .cutoff(cutoff),
    .h_count_out(h_count_out),
    .v_count_out(v_count_out),
    .active_draw_out(active_draw_out),
    .pixel_out(pixel_out)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(timeout_ns);
    $display("Timeout: the test sequence did not finish within %0d ns", timeout_ns);
    $display("Simulation failed");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, expected);
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // tap k of either direction uses coefficient |k - centre|
  function automatic int coeff_of(input int strength, input int tap);
    int offset;
    offset = (tap < centre_tap) ? centre_tap - tap : tap - centre_tap;
    return int'(blur_coeff_pkg::coeff_table[strength][offset]);
  endfunction

  function automatic int quant_chan(input int value, input int x, input int y);
    int dither;
    int sum;
    case ({y[0], x[0]})
      2'b00: dither = 0;
      2'b01: dither = 2;
      2'b10: dither = 3;
      default: dither = 1;
    endcase
    sum = value + dither;
    if (sum > 255) begin
      sum = 255;
    end
    return sum / 4;
  endfunction

  // output (h, v) is centred on input (h-4, v-4)
  function automatic pixel_t model_pixel(input int h, input int v, input int strength);
    pixel_t result;
    int vsum;
    int hsum;
    int x;
    int y;
    for (int c = 0; c < 3; c++) begin
      hsum = 0;
      for (int j = 0; j < video_fmt_pkg::kernel_taps; j++) begin
        x = h - span + j;
        vsum = 0;
        for (int k = 0; k < video_fmt_pkg::kernel_taps; k++) begin
          y = v - span + k;
          if (x >= 0 && x < video_fmt_pkg::h_active && y >= 0 && y < video_fmt_pkg::v_active) begin
            vsum += quant_chan(int'(frame[y][x][c*8 +: 8]), x, y) * coeff_of(strength, k);
          end
        end
        hsum += (vsum / 64) * coeff_of(strength, j);
      end
      result[c*8 +: 8] = 8'(hsum / 256);
    end
    return result;
  endfunction

  // white quantizes to 63 whatever the dither
  function automatic pixel_t impulse_value(input int dx, input int dy, input int strength);
    int vert;
    int chan;
    if (dx < -centre_tap || dx > centre_tap || dy < -centre_tap || dy > centre_tap) begin
      return '0;
    end
    vert = (63 * coeff_of(strength, centre_tap + dy)) / 64;
    chan = (vert * coeff_of(strength, centre_tap + dx)) / 256;
    return {3{8'(chan)}};
  endfunction

  always @(posedge clk) begin
    input_history.push_back('{h: h_count_in, v: v_count_in, active: active_draw_in});
    if (input_history.size() > video_fmt_pkg::pipe_latency) begin
      input_history.delete(0);
    end
  end

  always @(negedge clk) begin
    if (!rst && int'(h_count_out) < video_fmt_pkg::h_total &&
        int'(v_count_out) < video_fmt_pkg::v_total) begin
      captured[int'(v_count_out)][int'(h_count_out)] = pixel_out;
    end
    if (latency_check_en && input_history.size() == video_fmt_pkg::pipe_latency) begin
      check_value("h_count_out", 32'(h_count_out), 32'(input_history[0].h));
      check_value("v_count_out", 32'(v_count_out), 32'(input_history[0].v));
      check_value("active_draw_out", 32'(active_draw_out), 32'(input_history[0].active));
    end
  end

  task automatic drive_frame(input logic [1:0] next_strength);
    frame_strength = pending_strength;
    for (int v = 0; v < video_fmt_pkg::v_total; v++) begin
      for (int h = 0; h < video_fmt_pkg::h_total; h++) begin
        captured[v][h] = 'x;
      end
    end
    for (int v = 0; v < video_fmt_pkg::v_total; v++) begin
      for (int h = 0; h < video_fmt_pkg::h_total; h++) begin
        @(negedge clk);
        // latched when the frame leaves the pipeline
        if (v == video_fmt_pkg::v_active / 2 && h == 0) begin
          cutoff = {next_strength, 8'h5a};
        end
        h_count_in = h_count_t'(h);
        v_count_in = v_count_t'(v);
        if (h < video_fmt_pkg::h_active && v < video_fmt_pkg::v_active) begin
          active_draw_in = 1'b1;
          pixel_in = frame[v][h];
        end else begin
          active_draw_in = 1'b0;
          pixel_in = '0;
        end
      end
    end
    pending_strength = next_strength;
  endtask

  task automatic fill_frame(input pixel_t colour, input logic use_random);
    for (int v = 0; v < video_fmt_pkg::v_active; v++) begin
      for (int h = 0; h < video_fmt_pkg::h_active; h++) begin
        frame[v][h] = use_random ? pixel_t'(lcg_next() >> 8) : colour;
      end
    end
  endtask

  task automatic check_frame(input int strength, input logic flat, input pixel_t colour);
    for (int v = span; v < video_fmt_pkg::v_active; v++) begin
      for (int h = span; h < video_fmt_pkg::h_active; h++) begin
        check_value($sformatf("pixel_out(%0d,%0d)", h, v), 32'(captured[v][h]),
                    32'(flat ? colour : model_pixel(h, v, strength)));
      end
    end
  endtask

  task automatic reset_latency_test();
    rst = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_value("h_count_out", 32'(h_count_out), 32'd0);
      check_value("v_count_out", 32'(v_count_out), 32'd0);
      check_value("active_draw_out", 32'(active_draw_out), 32'd0);
      check_value("pixel_out", 32'(pixel_out), 32'd0);
    end
    rst = 1'b0;
    fill_frame(24'h000000, 1'b1);
    drive_frame(2'(blur_coeff_pkg::strength_none));
    latency_check_en = 1'b0;
  endtask

  // low bits 00 so the dither never carries into the kept bits
  task automatic flat_field_test(input logic [1:0] next_strength);
    fill_frame(24'h8040c0, 1'b0);
    drive_frame(2'(blur_coeff_pkg::strength_heavy));
    check_frame(int'(frame_strength), 1'b1, 24'h8040c0);
    drive_frame(next_strength);
    check_frame(int'(frame_strength), 1'b1, 24'h8040c0);
  endtask

  task automatic impulse_test(input logic [1:0] next_strength);
    fill_frame(24'h000000, 1'b0);
    frame[impulse_v][impulse_h] = 24'hffffff;
    drive_frame(next_strength);
    for (int v = span; v < video_fmt_pkg::v_active; v++) begin
      for (int h = span; h < video_fmt_pkg::h_active; h++) begin
        check_value($sformatf("pixel_out(%0d,%0d)", h, v), 32'(captured[v][h]),
                    32'(impulse_value(h - impulse_h - centre_tap, v - impulse_v - centre_tap,
                                      int'(frame_strength))));
      end
    end
  endtask

  task automatic random_test(input logic [1:0] next_strength);
    fill_frame(24'h000000, 1'b1);
    drive_frame(next_strength);
    check_frame(int'(frame_strength), 1'b0, 24'h000000);
  endtask

  // cutoff moves to heavy mid-frame, the swap waits for the frame boundary
  task automatic strength_change_test();
    fill_frame(24'h000000, 1'b1);
    drive_frame(2'(blur_coeff_pkg::strength_heavy));
    check_frame(int'(blur_coeff_pkg::strength_none), 1'b0, 24'h000000);
    fill_frame(24'h000000, 1'b1);
    drive_frame(2'(blur_coeff_pkg::strength_heavy));
    check_frame(int'(blur_coeff_pkg::strength_heavy), 1'b0, 24'h000000);
  endtask

  initial begin
    rst = 1'b1;
    h_count_in = '0;
    v_count_in = '0;
    active_draw_in = 1'b0;
    pixel_in = '0;
    cutoff = '0;
    latency_check_en = 1'b1;
    pending_strength = 2'(blur_coeff_pkg::strength_none);
    frame_strength = 2'(blur_coeff_pkg::strength_none);
    lcg_state = lcg_seed;
    errors = 0;
    checks = 0;

    reset_latency_test();
    flat_field_test(2'(blur_coeff_pkg::strength_medium));
    impulse_test(2'(blur_coeff_pkg::strength_light));
    random_test(2'(blur_coeff_pkg::strength_none));
    strength_change_test();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* gaussian_blur_top.f */
video_fmt_pkg.sv
blur_coeff_pkg.sv
dither_quantize.sv
line_buffer.sv
coeff_bank.sv
vertical_blur.sv
horizontal_blur.sv
gaussian_blur_top.sv
tb_gaussian_blur.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_gaussian_blur
FILELIST ?= gaussian_blur_top.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing
PASS_MSG ?= Simulation completed successfully

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN := $(OBJ_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
